//--- hw/policer_cfg_pkg.sv
/* Policer configuration definitions
   Table select encoding and fixed-point rate and burst types */
`default_nettype none

package policer_cfg_pkg;

    // Width of a configuration write word
    localparam int CFG_DATA_W = 32;

    // Fraction bits shared by CIR and bucket levels
    localparam int FRAC_BITS = 8;

    // Target table of a configuration write
    typedef enum logic [1:0] {
        SEL_CIR    = 2'd0,
        SEL_CBS    = 2'd1,
        SEL_ENABLE = 2'd2
    } table_sel_t;

    // Bytes per clock, FRAC_BITS below the binary point
    typedef logic [31:0] cir_t;

    // Burst size in whole bytes
    typedef logic [23:0] cbs_t;

endpackage : policer_cfg_pkg

`default_nettype wire

//--- hw/policer_pkt_pkg.sv
/* Policer packet definitions
   Descriptor field types and the bucket level format */
`default_nettype none

package policer_pkt_pkg;

    // Up to 16 ingress ports
    localparam int PORT_W = 4;

    // Ingress port index
    typedef logic [PORT_W-1:0] port_t;

    // Packet length in bytes
    typedef logic [15:0] byte_len_t;

    // Bucket fill in bytes, low bits are fraction
    // (same fraction width as the CIR)
    typedef logic [31:0] level_t;

endpackage : policer_pkt_pkg

`default_nettype wire

//--- hw/policer_tables.sv
/* Policer tables
   Per-port CIR, CBS and enable registers loaded by a write strobe */
`timescale 1ns/1ps
`default_nettype none

module policer_tables #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                         core_clk_ifc,
    input  logic                                         timer_reset,

    // Configuration write
    input  logic                                         cfg_wr,
    input  policer_cfg_pkg::table_sel_t                  cfg_sel,
    input  policer_pkt_pkg::port_t                       cfg_port,
    input  logic [policer_cfg_pkg::CFG_DATA_W-1:0]       cfg_data,

    // Table contents toward the meter
    output policer_cfg_pkg::cir_t [NUM_PORTS-1:0]        port_cir,
    output policer_cfg_pkg::cbs_t [NUM_PORTS-1:0]        port_cbs,
    output logic                  [NUM_PORTS-1:0]        port_enable
);

    import policer_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Write decode

    logic [NUM_PORTS-1:0] port_hit;

    // Indices at or above NUM_PORTS match no entry
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_hit[p] = cfg_wr && (int'(cfg_port) == p);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register files

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            port_cir    <= '0;
            port_cbs    <= '0;
            port_enable <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (port_hit[p]) begin
                    case (cfg_sel)
                        SEL_CIR: begin
                            port_cir[p] <= cir_t'(cfg_data);
                        end
                        SEL_CBS: begin
                            // Burst size only uses the low bits
                            port_cbs[p] <= cfg_data[$bits(cbs_t)-1:0];
                        end
                        SEL_ENABLE: begin
                            port_enable[p] <= cfg_data[0];
                        end
                        default: begin
                            // Unused select code, write dropped
                        end
                    endcase
                end
            end
        end
    end

endmodule : policer_tables

`default_nettype wire

//--- hw/bucket_meter.sv
/* Bucket meter
   Per-port leaky bucket with CIR drain, fill on accept and drop marking */
`timescale 1ns/1ps
`default_nettype none

module bucket_meter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                      core_clk_ifc,
    input  logic                                      timer_reset,

    // Incoming descriptor
    input  logic                                      pkt_valid,
    input  policer_pkt_pkg::port_t                    pkt_port,
    input  policer_pkt_pkg::byte_len_t                pkt_len,
    input  logic                                      space_ok,

    // Table contents
    input  policer_cfg_pkg::cir_t [NUM_PORTS-1:0]     port_cir,
    input  policer_cfg_pkg::cbs_t [NUM_PORTS-1:0]     port_cbs,
    input  logic                  [NUM_PORTS-1:0]     port_enable,

    // Marked descriptor toward the FIFO
    output logic                                      mark_valid,
    output policer_pkt_pkg::port_t                    mark_port,
    output policer_pkt_pkg::byte_len_t                mark_len,
    output logic                                      mark_drop
);

    import policer_cfg_pkg::*;
    import policer_pkt_pkg::*;

    // One extra bit so length plus level cannot wrap
    localparam int NEED_W  = $bits(cbs_t) + 1;
    localparam int WHOLE_W = $bits(level_t) - FRAC_BITS;

    level_t                 level   [NUM_PORTS];
    level_t                 drained [NUM_PORTS];
    logic   [NUM_PORTS-1:0] hit;

    logic                   sel_enable;
    level_t                 sel_level;
    cbs_t                   sel_cbs;
    logic   [NUM_PORTS-1:0] sel_hit;
    logic   [NUM_PORTS-1:0] fill;
    logic   [NEED_W-1:0]    need;
    logic                   accept;
    logic                   drop;

    //////////////////////////////////////////////////////////////////////
    // Drain and port select

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            // Saturate at an empty bucket
            if (level[p] > level_t'(port_cir[p])) begin
                drained[p] = level[p] - level_t'(port_cir[p]);
            end else begin
                drained[p] = '0;
            end
        end
    end

    always_comb begin
        sel_enable = 1'b0;
        sel_level  = '0;
        sel_cbs    = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            hit[p] = (int'(pkt_port) == p);
            if (hit[p]) begin
                sel_enable = port_enable[p];
                sel_level  = level[p];
                sel_cbs    = port_cbs[p];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drop decision

    assign accept = pkt_valid && space_ok;

    // Length plus whole bytes already in the bucket
    assign need = NEED_W'(sel_level[$bits(level_t)-1:FRAC_BITS])
                + NEED_W'(pkt_len);

    // Out-of-range ports select nothing, so they are never marked
    assign drop = sel_enable && (need > NEED_W'(sel_cbs));

    assign sel_hit = accept ? hit : '0;
    assign fill    = drop ? '0 : sel_hit;

    //////////////////////////////////////////////////////////////////////
    // Bucket levels

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                level[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!port_enable[p]) begin
                    level[p] <= '0;
                end else if (fill[p]) begin
                    // Cannot overflow, the CBS check bounds the whole part
                    level[p] <= drained[p] + {WHOLE_W'(pkt_len), FRAC_BITS'(0)};
                end else begin
                    level[p] <= drained[p];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered decision

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            mark_valid <= 1'b0;
        end else begin
            mark_valid <= accept;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            mark_port <= pkt_port;
            mark_len  <= pkt_len;
            mark_drop <= drop;
        end
    end

endmodule : bucket_meter

`default_nettype wire

//--- hw/mark_fifo.sv
/* Mark FIFO
   First-word-fall-through queue of metered descriptors */
`timescale 1ns/1ps
`default_nettype none

module mark_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                           core_clk_ifc,
    input  logic                           timer_reset,

    // Write side from the meter
    input  logic                           mark_valid,
    input  policer_pkt_pkg::port_t         mark_port,
    input  policer_pkt_pkg::byte_len_t     mark_len,
    input  logic                           mark_drop,
    output logic                           space_ok,

    // Read side, valid/ready
    output logic                           out_valid,
    output policer_pkt_pkg::port_t         out_port,
    output policer_pkt_pkg::byte_len_t     out_len,
    output logic                           out_drop,
    input  logic                           out_ready
);

    import policer_pkt_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    port_t              port_mem [FIFO_DEPTH];
    byte_len_t          len_mem  [FIFO_DEPTH];
    logic               drop_mem [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    // Wrap explicitly, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    // The meter only issues while space_ok was high, so a push never overflows
    assign push = mark_valid;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Room for one more plus the descriptor still in the meter
    assign space_ok = (count <= CNT_W'(FIFO_DEPTH - 2));

    //////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            port_mem[wr_ptr] <= mark_port;
            len_mem[wr_ptr]  <= mark_len;
            drop_mem[wr_ptr] <= mark_drop;
        end
    end

    // Head entry shown directly
    assign out_valid = (count != '0);
    assign out_port  = port_mem[rd_ptr];
    assign out_len   = len_mem[rd_ptr];
    assign out_drop  = drop_mem[rd_ptr];

endmodule : mark_fifo

`default_nettype wire

//--- hw/policer_top.sv
/* Ingress policer top level
   Connects the rate tables, the bucket meter and the mark FIFO */
`timescale 1ns/1ps
`default_nettype none

module policer_top #(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    timer_reset,

    // Configuration
    input  logic                                    cfg_wr,
    input  policer_cfg_pkg::table_sel_t             cfg_sel,
    input  policer_pkt_pkg::port_t                  cfg_port,
    input  logic [policer_cfg_pkg::CFG_DATA_W-1:0]  cfg_data,

    // Packet descriptors in
    input  logic                                    pkt_valid,
    input  policer_pkt_pkg::port_t                  pkt_port,
    input  policer_pkt_pkg::byte_len_t              pkt_len,
    output logic                                    pkt_ready,

    // Marked descriptors out
    output logic                                    out_valid,
    output policer_pkt_pkg::port_t                  out_port,
    output policer_pkt_pkg::byte_len_t              out_len,
    output logic                                    out_drop,
    input  logic                                    out_ready
);

    import policer_cfg_pkg::*;
    import policer_pkt_pkg::*;

    cir_t      [NUM_PORTS-1:0]  port_cir;
    cbs_t      [NUM_PORTS-1:0]  port_cbs;
    logic      [NUM_PORTS-1:0]  port_enable;

    logic                       mark_valid;
    port_t                      mark_port;
    byte_len_t                  mark_len;
    logic                       mark_drop;

    //////////////////////////////////////////////////////////////////////
    // Configuration tables

    policer_tables #(
        .NUM_PORTS   ( NUM_PORTS   )
    ) tables_i (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .cfg_wr       ( cfg_wr       ),
        .cfg_sel      ( cfg_sel      ),
        .cfg_port     ( cfg_port     ),
        .cfg_data     ( cfg_data     ),
        .port_cir     ( port_cir     ),
        .port_cbs     ( port_cbs     ),
        .port_enable  ( port_enable  )
    );

    //////////////////////////////////////////////////////////////////////
    // Meter and output queue

    // pkt_ready is the FIFO space flag, seen by the meter too
    bucket_meter #(
        .NUM_PORTS   ( NUM_PORTS   )
    ) meter_i (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .pkt_valid    ( pkt_valid    ),
        .pkt_port     ( pkt_port     ),
        .pkt_len      ( pkt_len      ),
        .space_ok     ( pkt_ready    ),
        .port_cir     ( port_cir     ),
        .port_cbs     ( port_cbs     ),
        .port_enable  ( port_enable  ),
        .mark_valid   ( mark_valid   ),
        .mark_port    ( mark_port    ),
        .mark_len     ( mark_len     ),
        .mark_drop    ( mark_drop    )
    );

    mark_fifo #(
        .FIFO_DEPTH  ( FIFO_DEPTH  )
    ) fifo_i (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .mark_valid   ( mark_valid   ),
        .mark_port    ( mark_port    ),
        .mark_len     ( mark_len     ),
        .mark_drop    ( mark_drop    ),
        .space_ok     ( pkt_ready    ),
        .out_valid    ( out_valid    ),
        .out_port     ( out_port     ),
        .out_len      ( out_len      ),
        .out_drop     ( out_drop     ),
        .out_ready    ( out_ready    )
    );

endmodule : policer_top

`default_nettype wire

//--- tests/policer_checker.sv
/* Policer port checker
   Assertions on the output handshake, reset state and port range */
`timescale 1ns/1ps
`default_nettype none

module policer_checker #(
    parameter int NUM_PORTS = 4
) (
    input  logic                        core_clk_ifc,
    input  logic                        timer_reset,
    input  logic                        pkt_valid,
    input  logic                        pkt_ready,
    input  policer_pkt_pkg::port_t      pkt_port,
    input  logic                        out_valid,
    input  logic                        out_ready,
    input  policer_pkt_pkg::port_t      out_port,
    input  policer_pkt_pkg::byte_len_t  out_len,
    input  logic                        out_drop
);

    int unsigned fail_count = 0;

    // Head of the queue holds under back-pressure
    out_hold: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_port)
            && $stable(out_len) && $stable(out_drop)))
    else begin
        $error("Output changed while out_ready was low");
        fail_count++;
    end

    reset_idle: assert property (@(posedge core_clk_ifc) timer_reset |=> !out_valid)
    else begin
        $error("out_valid high in the cycle after reset");
        fail_count++;
    end

    port_range: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        (pkt_valid && pkt_ready) |-> (int'(pkt_port) < NUM_PORTS))
    else begin
        $error("Accepted descriptor with port out of range");
        fail_count++;
    end

endmodule : policer_checker

bind policer_top policer_checker #(
    .NUM_PORTS ( NUM_PORTS )
) checker_i (
    .core_clk_ifc ( core_clk_ifc ),
    .timer_reset  ( timer_reset  ),
    .pkt_valid    ( pkt_valid    ),
    .pkt_ready    ( pkt_ready    ),
    .pkt_port     ( pkt_port     ),
    .out_valid    ( out_valid    ),
    .out_ready    ( out_ready    ),
    .out_port     ( out_port     ),
    .out_len      ( out_len      ),
    .out_drop     ( out_drop     )
);

`default_nettype wire

//--- tests/policer_tb.sv
/* Policer testbench
   Directed tests against a leaky bucket model with an output sink */
`timescale 1ns/1ps
`default_nettype none

module policer_tb;

    import policer_cfg_pkg::*;
    import policer_pkt_pkg::*;

    localparam int NUM_PORTS  = 4;
    localparam int WAIT_LIMIT = 5000;

    logic                   core_clk_ifc;
    logic                   timer_reset;
    logic                   cfg_wr;
    table_sel_t             cfg_sel;
    port_t                  cfg_port;
    logic [CFG_DATA_W-1:0]  cfg_data;
    logic                   pkt_valid;
    port_t                  pkt_port;
    byte_len_t              pkt_len;
    logic                   pkt_ready;
    logic                   out_valid;
    port_t                  out_port;
    byte_len_t              out_len;
    logic                   out_drop;
    logic                   out_ready;

    logic [31:0]            lfsr_state = 32'h7ea2_457f;
    int                     cycle_count = 0;
    string                  test_name;
    logic [20:0]            expect_q[$];

    // Bucket model in whole bytes with no drain
    int                     model_cbs [NUM_PORTS];
    int                     model_lvl [NUM_PORTS];
    logic                   model_en  [NUM_PORTS];

    policer_top #(
        .NUM_PORTS  ( NUM_PORTS ),
        .FIFO_DEPTH ( 8         )
    ) dut_i (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .cfg_wr       ( cfg_wr       ),
        .cfg_sel      ( cfg_sel      ),
        .cfg_port     ( cfg_port     ),
        .cfg_data     ( cfg_data     ),
        .pkt_valid    ( pkt_valid    ),
        .pkt_port     ( pkt_port     ),
        .pkt_len      ( pkt_len      ),
        .pkt_ready    ( pkt_ready    ),
        .out_valid    ( out_valid    ),
        .out_port     ( out_port     ),
        .out_len      ( out_len      ),
        .out_drop     ( out_drop     ),
        .out_ready    ( out_ready    )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // Whole bytes left after a full 1000-byte fill drains for some edges
    function automatic int whole_left(input cir_t cir, input int edges);
        longint lvl;
        lvl = 64'sd256000 - longint'(edges) * longint'(cir);
        return (lvl > 0) ? int'(lvl >>> 8) : 0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s %s: expected %0h, actual %0h",
                     test_name, field, expected, actual);
            abort_run("Output descriptor mismatch");
        end
    endtask

    task automatic write_cfg(input table_sel_t sel, input int port,
                             input logic [CFG_DATA_W-1:0] data);
        cfg_wr   = 1'b1;
        cfg_sel  = sel;
        cfg_port = port_t'(port);
        cfg_data = data;
        @(posedge core_clk_ifc);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic setup_port(input int port, input cir_t cir, input cbs_t cbs,
                              input logic en);
        // Disabling first empties the bucket
        write_cfg(SEL_ENABLE, port, 32'h0);
        write_cfg(SEL_CIR, port, cir);
        write_cfg(SEL_CBS, port, 32'(cbs));
        write_cfg(SEL_ENABLE, port, {31'h0, en});
        model_cbs[port] = int'(cbs);
        model_lvl[port] = 0;
        model_en[port]  = en;
    endtask

    task automatic send_pkt(input int port, input int len, output int accepted_at);
        int waited;
        waited    = 0;
        pkt_valid = 1'b1;
        pkt_port  = port_t'(port);
        pkt_len   = byte_len_t'(len);
        while (!pkt_ready) begin
            @(posedge core_clk_ifc);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timeout waiting for pkt_ready");
            end
        end
        @(posedge core_clk_ifc);
        #1;
        accepted_at = cycle_count;
        pkt_valid   = 1'b0;
    endtask

    task automatic push_expect(input int port, input int len, input logic drop);
        expect_q.push_back({port_t'(port), byte_len_t'(len), drop});
    endtask

    task automatic send_random(input int count);
        int   port;
        int   len;
        int   acc;
        logic drop;
        for (int i = 0; i < count; i++) begin
            port = int'(rand_bits(2));
            len  = int'(rand_bits(11)) + 1;
            drop = model_en[port] && (model_lvl[port] + len > model_cbs[port]);
            if (model_en[port] && !drop) begin
                model_lvl[port] += len;
            end
            send_pkt(port, len, acc);
            push_expect(port, len, drop);
        end
    endtask

    // Sink checks the head in the cycle before its handshake edge
    task automatic drain_outputs(input int count);
        int          waited;
        logic [20:0] want;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            do begin
                @(posedge core_clk_ifc);
                #2;
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("Timeout waiting for an output descriptor");
                end
            end while (!(out_valid && out_ready));
            if (expect_q.size() == 0) begin
                abort_run("Output descriptor arrived with nothing expected");
            end
            want = expect_q.pop_front();
            check_value("port", 32'(want[20:17]), 32'(out_port));
            check_value("len", 32'(want[16:1]), 32'(out_len));
            check_value("drop", 32'(want[0]), 32'(out_drop));
        end
        @(posedge core_clk_ifc);
        #1;
    endtask

    task automatic run_traffic(input int count);
        fork
            send_random(count);
            drain_outputs(count);
        join
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests

    task automatic test_drop_all();
        test_name = "drop_all";
        for (int p = 0; p < NUM_PORTS; p++) begin
            setup_port(p, '0, '0, 1'b1);
        end
        run_traffic(60);
    endtask

    task automatic test_accept_all();
        test_name = "accept_all";
        for (int p = 0; p < NUM_PORTS; p++) begin
            setup_port(p, 32'hFFFF_FFFF, 24'hFF_FFFF, 1'b1);
        end
        run_traffic(40);
    endtask

    task automatic test_cbs_fill();
        test_name = "cbs_fill";
        for (int p = 0; p < NUM_PORTS; p++) begin
            setup_port(p, '0, cbs_t'(rand_bits(12)), 1'b1);
        end
        run_traffic(60);
    endtask

    task automatic test_cir_drain();
        int   first_at;
        int   second_at;
        int   third_at;
        int   waited;
        int   left;
        cir_t cir;
        test_name = "cir_drain";
        for (int p = 0; p < NUM_PORTS; p++) begin
            // 1 to 17 bytes per clock
            cir = 32'd256 + rand_bits(12);
            setup_port(p, cir, 24'd1000, 1'b1);
            fork
                begin
                    send_pkt(p, 1000, first_at);
                    push_expect(p, 1000, 1'b0);
                    send_pkt(p, 1000, second_at);
                    left = whole_left(cir, second_at - first_at);
                    if (left < 8) begin
                        abort_run("Second packet sent after the bucket drained too far");
                    end
                    push_expect(p, 1000, left >= 1);
                    waited = 0;
                    while (cycle_count < first_at + 256000 / int'(cir) + 4) begin
                        @(posedge core_clk_ifc);
                        #1;
                        waited++;
                        if (waited > WAIT_LIMIT) begin
                            abort_run("Timeout waiting for the bucket to drain");
                        end
                    end
                    send_pkt(p, 1000, third_at);
                    push_expect(p, 1000, whole_left(cir, third_at - first_at) >= 1);
                end
                drain_outputs(3);
            join
        end
    endtask

    task automatic test_disable();
        test_name = "disable";
        for (int p = 0; p < NUM_PORTS; p++) begin
            setup_port(p, '0, '0, 1'(rand_bits(1)));
        end
        run_traffic(40);
    endtask

    task automatic test_back_pressure();
        int waited;
        test_name = "back_pressure";
        for (int p = 0; p < NUM_PORTS; p++) begin
            setup_port(p, '0, '0, 1'b1);
        end
        out_ready = 1'b0;
        fork
            send_random(24);
            begin
                waited = 0;
                while (pkt_ready) begin
                    @(posedge core_clk_ifc);
                    #1;
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        abort_run("Timeout waiting for pkt_ready to fall");
                    end
                end
                out_ready = 1'b1;
            end
            drain_outputs(24);
        join
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    always @(posedge core_clk_ifc) begin
        if (dut_i.checker_i.fail_count != 0) begin
            abort_run("An assertion in the port checker failed");
        end
    end

    initial begin
        timer_reset = 1'b1;
        cfg_wr      = 1'b0;
        cfg_sel     = SEL_CIR;
        cfg_port    = '0;
        cfg_data    = '0;
        pkt_valid   = 1'b0;
        pkt_port    = '0;
        pkt_len     = '0;
        out_ready   = 1'b1;
        repeat (3) @(posedge core_clk_ifc);
        #1;
        timer_reset = 1'b0;
        test_drop_all();
        test_accept_all();
        test_cbs_fill();
        test_cir_drain();
        test_disable();
        test_back_pressure();
        if (expect_q.size() != 0) begin
            abort_run("Expected descriptors never came out");
        end else if (out_valid) begin
            abort_run("Output descriptor left over with nothing expected");
        end else if (dut_i.checker_i.fail_count != 0) begin
            abort_run("An assertion in the port checker failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule : policer_tb

`default_nettype wire

//--- flist.f
hw/policer_cfg_pkg.sv
hw/policer_pkt_pkg.sv
hw/policer_tables.sv
hw/bucket_meter.sv
hw/mark_fifo.sv
hw/policer_top.sv
tests/policer_checker.sv
tests/policer_tb.sv
